//--- all.f
hdl/regmst_bus_pkg.sv
hdl/regmst_map_pkg.sv
hdl/err_field.sv
hdl/snapshot_reg.sv
hdl/root_regfile.sv
hdl/apb_mst_fsm.sv
hdl/regmst_top.sv
dv/regmst_assert.sv
dv/regmst_tb.sv

//--- dv/regmst_stimulus.txt
# Columns: op field address data expected, numbers in hex
# op W write, R read, H hardware pulse, B pulse during a write
# field A err_addr, L word at 0x8, I intr, S soft_reset, - none
R - 0000000000000000 0 0
R - 0000000000000004 0 0
R - 0000000000000008 0 0
W L 0000000000000008 3 3
R - 0000000000000008 0 3
W L 0000000000000008 2 2
R - 0000000000000008 0 2
H I 0000000000000000 1 1
H S 0000000000000000 0 0
R - 0000000000000008 0 1
B I 0000000000000008 0 0
R - 0000000000000008 0 0
B S 0000000000000008 2 1
R - 0000000000000008 0 2
W A 0000000000000000 11223344 0
R - 0000000000000000 0 0
W A 0000000000000004 aabbccdd aabbccdd11223344
R - 0000000000000000 0 11223344
R - 0000000000000004 0 aabbccdd
R - 0000000000000000 0 11223344
H A 0000000000000000 5555666677778888 5555666677778888
R - 0000000000000004 0 aabbccdd
R - 0000000000000000 0 77778888
R - 0000000000000004 0 55556666
W A 0000000000000000 deadbeef 5555666677778888
B A 0000000000000004 01020304 01020304deadbeef
R - 0000000000000000 0 deadbeef
R - 0000000000000004 0 01020304
W - 0000000000000100 cafef00d 0
R - 1234567890abcdef 0 90abcdef
R - 0000000000000020 0 00000020
W - 000000000000000c 5a5a5a5a 0

//--- dv/regmst_tb.sv
`timescale 1ns/1ns
`default_nettype none

module regmst_tb import regmst_bus_pkg::*, regmst_map_pkg::*; ();

	logic                  pclk;
	logic                  arst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [ADDR_W-1:0]     paddr;
	logic [DATA_W-1:0]     pwdata;
	logic                  pready;
	logic [DATA_W-1:0]     prdata;
	logic                  ext_req_vld;
	access_op_e            ext_op;
	logic [ADDR_W-1:0]     ext_addr;
	logic [DATA_W-1:0]     ext_wr_data;
	logic                  ext_ack_vld;
	logic [DATA_W-1:0]     ext_rd_data;
	logic [ERR_ADDR_W-1:0] err_addr_next;
	logic                  err_addr_pulse;
	logic [ERR_ADDR_W-1:0] err_addr_curr;
	logic                  intr_next;
	logic                  intr_pulse;
	logic                  intr_curr;
	logic                  soft_reset_next;
	logic                  soft_reset_pulse;
	logic                  soft_reset_curr;

	// Parsed stimulus lines
	logic [7:0]  stim_op[$];
	logic [7:0]  stim_fld[$];
	logic [63:0] stim_addr[$];
	logic [63:0] stim_data[$];
	logic [63:0] stim_exp[$];
	logic        loaded = 1'b0;

	// What the responder expects for the transfer in flight
	logic              exp_ext = 1'b0;
	access_op_e        exp_op = OP_NONE;
	logic [ADDR_W-1:0] exp_addr = '0;
	logic [DATA_W-1:0] exp_wdata = '0;

	int          mismatch_cnt = 0;
	int          other_cnt = 0;
	logic [31:0] lfsr = 32'hb398_edd7;

	regmst_top i_dut (
		.pclk_i             (pclk),
		.arst_n_i           (arst_n),
		.psel_i             (psel),
		.penable_i          (penable),
		.pwrite_i           (pwrite),
		.paddr_i            (paddr),
		.pwdata_i           (pwdata),
		.pready_o           (pready),
		.prdata_o           (prdata),
		.ext_req_vld_o      (ext_req_vld),
		.ext_op_o           (ext_op),
		.ext_addr_o         (ext_addr),
		.ext_wr_data_o      (ext_wr_data),
		.ext_ack_vld_i      (ext_ack_vld),
		.ext_rd_data_i      (ext_rd_data),
		.err_addr_next_i    (err_addr_next),
		.err_addr_pulse_i   (err_addr_pulse),
		.err_addr_curr_o    (err_addr_curr),
		.intr_next_i        (intr_next),
		.intr_pulse_i       (intr_pulse),
		.intr_curr_o        (intr_curr),
		.soft_reset_next_i  (soft_reset_next),
		.soft_reset_pulse_i (soft_reset_pulse),
		.soft_reset_curr_o  (soft_reset_curr)
	);

	// 40 ns clock
	initial pclk = 1'b0;
	always #20 pclk = ~pclk;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Three bits, one step each
	task automatic draw_delay(output int d);
		int i;
		d = 0;
		for (i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			d = (d << 1) | lfsr[0];
		end
	endtask

	function automatic logic is_internal(input logic [ADDR_W-1:0] a);
		return (a == SNAP_LO_ADDR) || (a == SNAP_HI_ADDR) || (a == ERR_LOG_1_ADDR);
	endfunction

	// Field letters: A err_addr, L whole 0x8 word, I intr, S soft_reset
	function automatic logic [63:0] curr_value(input logic [7:0] fld);
		logic [63:0] w;
		w = '0;
		case (fld)
			"A": w = err_addr_curr;
			"I": w[0] = intr_curr;
			"S": w[0] = soft_reset_curr;
			"L": begin
				w[INTR_BIT]       = intr_curr;
				w[SOFT_RESET_BIT] = soft_reset_curr;
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic string field_name(input logic [7:0] fld);
		case (fld)
			"A": return "err_addr_curr_o";
			"I": return "intr_curr_o";
			"S": return "soft_reset_curr_o";
			default: return "soft_reset_curr_o/intr_curr_o";
		endcase
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic drive_pulse(input logic [7:0] fld, input logic [63:0] val);
		case (fld)
			"A": begin
				err_addr_next  = val;
				err_addr_pulse = 1'b1;
			end
			"I": begin
				intr_next  = val[0];
				intr_pulse = 1'b1;
			end
			"S": begin
				soft_reset_next  = val[0];
				soft_reset_pulse = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic clear_pulses();
		err_addr_pulse   = 1'b0;
		intr_pulse       = 1'b0;
		soft_reset_pulse = 1'b0;
	endtask

	// One APB transfer, with an optional pulse in the request cycle
	task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [7:0] pulse_fld,
			input logic [63:0] pulse_val, output logic [DATA_W-1:0] rdata);
		int k;
		exp_ext   = !is_internal(addr);
		exp_op    = wr ? OP_WR : OP_RD;
		exp_addr  = addr;
		exp_wdata = wdata;
		// Setup phase
		@(negedge pclk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		// Access phase, next rising edge is edge n
		@(negedge pclk);
		penable = 1'b1;
		k = 0;
		do begin
			@(negedge pclk);
			k++;
			// Second falling edge sits in the req cycle
			if (k == 2) begin
				drive_pulse(pulse_fld, pulse_val);
			end
			if (k == 3) begin
				clear_pulses();
			end
		end while (!pready);
		rdata = prdata;
		// Internal pready in the cycle from edge n+3
		if (!exp_ext) begin
			check_val("pready_o latency", k, 4);
		end
		@(negedge pclk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic load_stimulus();
		int          fd;
		int          c;
		int          n;
		logic [7:0]  fld;
		logic [63:0] a;
		logic [63:0] d;
		logic [63:0] e;
		fd = $fopen("dv/regmst_stimulus.txt", "r");
		if (fd == 0) begin
			other_cnt++;
			$display("Could not open the stimulus file");
			return;
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				// Skip comment to end of line
				while (c != -1 && c != "\n") begin
					c = $fgetc(fd);
				end
			end else if (c == "W" || c == "R" || c == "H" || c == "B") begin
				n = $fscanf(fd, " %c %h %h %h", fld, a, d, e);
				if (n == 4) begin
					stim_op.push_back(c[7:0]);
					stim_fld.push_back(fld);
					stim_addr.push_back(a);
					stim_data.push_back(d);
					stim_exp.push_back(e);
				end else begin
					other_cnt++;
					$display("Stimulus line for op %c could not be parsed", c);
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (stim_op.size() == 0) begin
			other_cnt++;
			$display("No stimulus lines were read");
		end
	endtask

	// External side, acks after a random delay
	initial begin : responder
		int                d;
		logic [DATA_W-1:0] rsp;
		ext_ack_vld = 1'b0;
		ext_rd_data = '0;
		forever begin
			@(negedge pclk);
			if (ext_req_vld) begin
				assert (exp_ext) else begin
					other_cnt++;
					$display("External request seen for internal address %h", ext_addr);
				end
				check_val("ext_op_o", ext_op, exp_op);
				check_val("ext_addr_o", ext_addr, exp_addr);
				if (exp_op == OP_WR) begin
					check_val("ext_wr_data_o", ext_wr_data, exp_wdata);
				end
				rsp = ext_addr[DATA_W-1:0];
				draw_delay(d);
				// At least one cycle after the request
				repeat (d + 1) @(negedge pclk);
				ext_ack_vld = 1'b1;
				ext_rd_data = rsp;
				@(negedge pclk);
				ext_ack_vld = 1'b0;
				ext_rd_data = '0;
				assert (pready) else begin
					other_cnt++;
					$display("pready_o did not follow the external ack");
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		// 40 cycles a line, longest ack delay, reset
		limit = stim_op.size() * 40 + 8 + 20;
		repeat (limit) @(posedge pclk);
		$display("Timeout after %0d cycles, the test did not complete", limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : main
		int                i;
		int                total;
		logic [7:0]        pfld;
		logic [DATA_W-1:0] rd;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		err_addr_next   = '0;
		intr_next       = 1'b0;
		soft_reset_next = 1'b0;
		clear_pulses();
		arst_n = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (5) @(negedge pclk);
		arst_n = 1'b1;
		@(negedge pclk);
		// Reset state
		check_val("pready_o", pready, 0);
		check_val("ext_req_vld_o", ext_req_vld, 0);
		check_val("err_addr_curr_o", err_addr_curr, 0);
		check_val("intr_curr_o", intr_curr, 0);
		check_val("soft_reset_curr_o", soft_reset_curr, 0);
		for (i = 0; i < stim_op.size(); i++) begin
			case (stim_op[i])
				"R": begin
					apb_xfer(1'b0, stim_addr[i], '0, "-", '0, rd);
					check_val("prdata_o", rd, stim_exp[i]);
				end
				"H": begin
					@(negedge pclk);
					drive_pulse(stim_fld[i], stim_data[i]);
					@(negedge pclk);
					clear_pulses();
					check_val(field_name(stim_fld[i]), curr_value(stim_fld[i]), stim_exp[i]);
				end
				default: begin
					// B pulses the complement, which must lose
					pfld = (stim_op[i] == "B") ? stim_fld[i] : "-";
					apb_xfer(1'b1, stim_addr[i], stim_data[i][DATA_W-1:0], pfld,
						~stim_exp[i], rd);
					if (stim_fld[i] != "-") begin
						check_val(field_name(stim_fld[i]), curr_value(stim_fld[i]),
							stim_exp[i]);
					end
				end
			endcase
		end
		repeat (4) @(negedge pclk);
		total = mismatch_cnt + other_cnt + i_dut.i_fsm.i_assert.fail_cnt;
		$display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_cnt, other_cnt, i_dut.i_fsm.i_assert.fail_cnt);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/regmst_assert.sv
`timescale 1ns/1ns
`default_nettype none

module regmst_assert (
	input wire logic pclk_i,
	input wire logic arst_n_i,
	input wire logic pready_i,
	input wire logic req_vld_i
);

	// Failed assertion count
	int fail_cnt = 0;

	// Completion is a single-cycle pulse
	a_pready_pulse: assert property (
		@(posedge pclk_i) disable iff (!arst_n_i) pready_i |=> !pready_i
	) else begin
		fail_cnt++;
		$error("pready_o stayed high for more than one cycle");
	end

	// Request is a single-cycle pulse
	a_req_pulse: assert property (
		@(posedge pclk_i) disable iff (!arst_n_i) req_vld_i |=> !req_vld_i
	) else begin
		fail_cnt++;
		$error("req_vld_o stayed high for more than one cycle");
	end

	// No new request before the previous transfer completes
	a_req_before_pready: assert property (
		@(posedge pclk_i) disable iff (!arst_n_i)
		req_vld_i |=> !req_vld_i throughout pready_i [->1]
	) else begin
		fail_cnt++;
		$error("new request issued before pready_o of the previous one");
	end

endmodule

bind apb_mst_fsm regmst_assert i_assert (
	.pclk_i    (pclk_i),
	.arst_n_i  (arst_n_i),
	.pready_i  (pready_o),
	.req_vld_i (req_vld_o)
);

`default_nettype wire

//--- hdl/regmst_top.sv
`timescale 1ns/1ns
`default_nettype none

module regmst_top import regmst_bus_pkg::*, regmst_map_pkg::*; (
	input  wire logic                  pclk_i,
	input  wire logic                  arst_n_i,
	input  wire logic                  psel_i,
	input  wire logic                  penable_i,
	input  wire logic                  pwrite_i,
	input  wire logic [ADDR_W-1:0]     paddr_i,
	input  wire logic [DATA_W-1:0]     pwdata_i,
	output logic                       pready_o,
	output logic      [DATA_W-1:0]     prdata_o,
	output logic                       ext_req_vld_o,
	output access_op_e                 ext_op_o,
	output logic      [ADDR_W-1:0]     ext_addr_o,
	output logic      [DATA_W-1:0]     ext_wr_data_o,
	input  wire logic                  ext_ack_vld_i,
	input  wire logic [DATA_W-1:0]     ext_rd_data_i,
	input  wire logic [ERR_ADDR_W-1:0] err_addr_next_i,
	input  wire logic                  err_addr_pulse_i,
	output logic      [ERR_ADDR_W-1:0] err_addr_curr_o,
	input  wire logic                  intr_next_i,
	input  wire logic                  intr_pulse_i,
	output logic                       intr_curr_o,
	input  wire logic                  soft_reset_next_i,
	input  wire logic                  soft_reset_pulse_i,
	output logic                       soft_reset_curr_o
);

	// Bridge request
	logic              req_vld;
	access_op_e        req_op;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wr_data;
	// Register file response
	logic              hit;
	logic              rf_ack_vld;
	logic [DATA_W-1:0] rf_rd_data;
	// Merged response back to the bridge
	logic              ack_vld;
	logic [DATA_W-1:0] ack_rd_data;

	apb_mst_fsm i_fsm (
		.pclk_i        (pclk_i),
		.arst_n_i      (arst_n_i),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.pready_o      (pready_o),
		.prdata_o      (prdata_o),
		.req_vld_o     (req_vld),
		.req_op_o      (req_op),
		.req_addr_o    (req_addr),
		.req_wr_data_o (req_wr_data),
		.ack_vld_i     (ack_vld),
		.ack_rd_data_i (ack_rd_data)
	);

	root_regfile i_regfile (
		.pclk_i             (pclk_i),
		.arst_n_i           (arst_n_i),
		.req_vld_i          (req_vld),
		.req_op_i           (req_op),
		.req_addr_i         (req_addr),
		.req_wr_data_i      (req_wr_data),
		.hit_o              (hit),
		.ack_vld_o          (rf_ack_vld),
		.rd_data_o          (rf_rd_data),
		.err_addr_next_i    (err_addr_next_i),
		.err_addr_pulse_i   (err_addr_pulse_i),
		.err_addr_curr_o    (err_addr_curr_o),
		.intr_next_i        (intr_next_i),
		.intr_pulse_i       (intr_pulse_i),
		.intr_curr_o        (intr_curr_o),
		.soft_reset_next_i  (soft_reset_next_i),
		.soft_reset_pulse_i (soft_reset_pulse_i),
		.soft_reset_curr_o  (soft_reset_curr_o)
	);

	// Misses go out to the external port
	assign ext_req_vld_o = req_vld & ~hit;
	assign ext_op_o      = req_op;
	assign ext_addr_o    = req_addr;
	assign ext_wr_data_o = req_wr_data;

	// Only one side acks per transfer
	assign ack_vld     = rf_ack_vld | ext_ack_vld_i;
	assign ack_rd_data = rf_ack_vld    ? rf_rd_data    :
	                     ext_ack_vld_i ? ext_rd_data_i : '0;

endmodule

`default_nettype wire

//--- hdl/apb_mst_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module apb_mst_fsm import regmst_bus_pkg::*; (
	input  wire logic              pclk_i,
	input  wire logic              arst_n_i,
	input  wire logic              psel_i,
	input  wire logic              penable_i,
	input  wire logic              pwrite_i,
	input  wire logic [ADDR_W-1:0] paddr_i,
	input  wire logic [DATA_W-1:0] pwdata_i,
	output logic                   pready_o,
	output logic      [DATA_W-1:0] prdata_o,
	output logic                   req_vld_o,
	output access_op_e             req_op_o,
	output logic      [ADDR_W-1:0] req_addr_o,
	output logic      [DATA_W-1:0] req_wr_data_o,
	input  wire logic              ack_vld_i,
	input  wire logic [DATA_W-1:0] ack_rd_data_i
);

	bridge_state_e     state_q;
	access_op_e        op_q;
	logic              req_vld_q;
	logic              pready_q;
	logic              start;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;

	// Access phase of a new transfer
	// the completing transfer still shows psel and penable while pready is high
	assign start = psel_i & penable_i & ~pready_q;

	// Bridge FSM
	always_ff @(posedge pclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= IDLE;
			op_q      <= OP_NONE;
			req_vld_q <= 1'b0;
			pready_q  <= 1'b0;
		end else begin
			// Both are single-cycle pulses
			req_vld_q <= 1'b0;
			pready_q  <= 1'b0;
			unique case (state_q)
				IDLE: begin
					if (start) begin
						op_q    <= pwrite_i ? OP_WR : OP_RD;
						state_q <= REQ;
					end
				end
				REQ: begin
					req_vld_q <= 1'b1;
					state_q   <= WAIT_ACK;
				end
				WAIT_ACK: begin
					// Master held here until either side acks
					if (ack_vld_i) begin
						op_q     <= OP_NONE;
						pready_q <= 1'b1;
						state_q  <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Transfer payload, latched at the access phase
	always_ff @(posedge pclk_i) begin
		if (state_q == IDLE && start) begin
			addr_q  <= paddr_i;
			wdata_q <= pwdata_i;
		end
	end

	// Read data held for the pready cycle
	always_ff @(posedge pclk_i) begin
		if (state_q == WAIT_ACK && ack_vld_i) begin
			rdata_q <= ack_rd_data_i;
		end
	end

	assign req_vld_o     = req_vld_q;
	assign req_op_o      = op_q;
	assign req_addr_o    = addr_q;
	assign req_wr_data_o = wdata_q;
	assign pready_o      = pready_q;
	assign prdata_o      = rdata_q;

endmodule

`default_nettype wire

//--- hdl/root_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module root_regfile import regmst_bus_pkg::*, regmst_map_pkg::*; (
	input  wire logic                  pclk_i,
	input  wire logic                  arst_n_i,
	input  wire logic                  req_vld_i,
	input  wire access_op_e            req_op_i,
	input  wire logic [ADDR_W-1:0]     req_addr_i,
	input  wire logic [DATA_W-1:0]     req_wr_data_i,
	output logic                       hit_o,
	output logic                       ack_vld_o,
	output logic      [DATA_W-1:0]     rd_data_o,
	input  wire logic [ERR_ADDR_W-1:0] err_addr_next_i,
	input  wire logic                  err_addr_pulse_i,
	output logic      [ERR_ADDR_W-1:0] err_addr_curr_o,
	input  wire logic                  intr_next_i,
	input  wire logic                  intr_pulse_i,
	output logic                       intr_curr_o,
	input  wire logic                  soft_reset_next_i,
	input  wire logic                  soft_reset_pulse_i,
	output logic                       soft_reset_curr_o
);

	logic                        sel_lo;
	logic                        sel_hi;
	logic                        sel_log1;
	logic                        int_req;
	logic                        wr_en;
	logic                        rd_en;
	logic [DATA_W-1:0]           snap_lo_data;
	logic [DATA_W-1:0]           snap_hi_data;
	logic [ERR_LOG_1_FIELDS-1:0] log1_next;
	logic [ERR_LOG_1_FIELDS-1:0] log1_pulse;
	logic [ERR_LOG_1_FIELDS-1:0] log1_val;
	logic [DATA_W-1:0]           rd_word;
	logic                        ack_q;
	logic [DATA_W-1:0]           rd_data_q;

	// Address decode
	assign sel_lo   = (req_addr_i == SNAP_LO_ADDR);
	assign sel_hi   = (req_addr_i == SNAP_HI_ADDR);
	assign sel_log1 = (req_addr_i == ERR_LOG_1_ADDR);
	// One hit flag, also used by the top to steer to the external port
	assign hit_o    = sel_lo | sel_hi | sel_log1;

	// Internal request only on a hit
	assign int_req = req_vld_i & hit_o;
	assign wr_en   = int_req & (req_op_i == OP_WR);
	assign rd_en   = int_req & (req_op_i == OP_RD);

	// Error address behind the snapshot buffer
	snapshot_reg i_snap (
		.pclk_i       (pclk_i),
		.arst_n_i     (arst_n_i),
		.lo_wr_i      (wr_en & sel_lo),
		.hi_wr_i      (wr_en & sel_hi),
		.lo_rd_i      (rd_en & sel_lo),
		.wr_data_i    (req_wr_data_i),
		.lo_rd_data_o (snap_lo_data),
		.hi_rd_data_o (snap_hi_data),
		.hw_next_i    (err_addr_next_i),
		.hw_pulse_i   (err_addr_pulse_i),
		.curr_o       (err_addr_curr_o)
	);

	// Hardware side of the 0x8 fields, packed by bit position
	assign log1_next[INTR_BIT]        = intr_next_i;
	assign log1_next[SOFT_RESET_BIT]  = soft_reset_next_i;
	assign log1_pulse[INTR_BIT]       = intr_pulse_i;
	assign log1_pulse[SOFT_RESET_BIT] = soft_reset_pulse_i;

	// One 1-bit field per bit of the 0x8 word
	for (genvar i = 0; i < ERR_LOG_1_FIELDS; i++) begin : g_log1
		err_field #(
			.FIELD_W (1)
		) i_field (
			.pclk_i     (pclk_i),
			.arst_n_i   (arst_n_i),
			.sw_wr_i    (wr_en & sel_log1),
			.sw_data_i  (req_wr_data_i[i]),
			.hw_pulse_i (log1_pulse[i]),
			.hw_next_i  (log1_next[i]),
			.value_o    (log1_val[i])
		);
	end

	assign intr_curr_o       = log1_val[INTR_BIT];
	assign soft_reset_curr_o = log1_val[SOFT_RESET_BIT];

	// Read word assembly
	// unused upper bits of 0x8 read as zero
	always_comb begin
		rd_word = '0;
		if (sel_lo) begin
			rd_word = snap_lo_data;
		end else if (sel_hi) begin
			rd_word = snap_hi_data;
		end else if (sel_log1) begin
			rd_word[ERR_LOG_1_FIELDS-1:0] = log1_val;
		end
	end

	// Ack one cycle after the request
	always_ff @(posedge pclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= int_req;
		end
	end

	// Read data, zero on a write ack
	always_ff @(posedge pclk_i) begin
		if (int_req) begin
			rd_data_q <= rd_en ? rd_word : '0;
		end
	end

	assign ack_vld_o = ack_q;
	assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hdl/snapshot_reg.sv
`timescale 1ns/1ns
`default_nettype none

module snapshot_reg import regmst_bus_pkg::*, regmst_map_pkg::*; (
	input  wire logic                  pclk_i,
	input  wire logic                  arst_n_i,
	input  wire logic                  lo_wr_i,
	input  wire logic                  hi_wr_i,
	input  wire logic                  lo_rd_i,
	input  wire logic [DATA_W-1:0]     wr_data_i,
	output logic      [DATA_W-1:0]     lo_rd_data_o,
	output logic      [DATA_W-1:0]     hi_rd_data_o,
	input  wire logic [ERR_ADDR_W-1:0] hw_next_i,
	input  wire logic                  hw_pulse_i,
	output logic      [ERR_ADDR_W-1:0] curr_o
);

	// Low word held until the high word arrives
	logic [DATA_W-1:0]     lo_buf_q;
	// High half captured on a low read
	logic [DATA_W-1:0]     hi_snap_q;
	logic [ERR_ADDR_W-1:0] field_val;

	// Buffer for the low half of a software write
	always_ff @(posedge pclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lo_buf_q <= {DATA_W{RST_VAL}};
		end else if (lo_wr_i) begin
			lo_buf_q <= wr_data_i;
		end
	end

	// Snapshot of the high half
	// taken at the same edge that returns the low half
	always_ff @(posedge pclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hi_snap_q <= {DATA_W{RST_VAL}};
		end else if (lo_rd_i) begin
			hi_snap_q <= field_val[ERR_ADDR_W-1:DATA_W];
		end
	end

	// 64-bit storage, committed by the high word write
	err_field #(
		.FIELD_W (ERR_ADDR_W)
	) i_field (
		.pclk_i     (pclk_i),
		.arst_n_i   (arst_n_i),
		.sw_wr_i    (hi_wr_i),
		.sw_data_i  ({wr_data_i, lo_buf_q}),
		.hw_pulse_i (hw_pulse_i),
		.hw_next_i  (hw_next_i),
		.value_o    (field_val)
	);

	// Low read sees the live value, high read the snapshot
	assign lo_rd_data_o = field_val[DATA_W-1:0];
	assign hi_rd_data_o = hi_snap_q;
	assign curr_o       = field_val;

endmodule

`default_nettype wire

//--- hdl/err_field.sv
`timescale 1ns/1ns
`default_nettype none

module err_field import regmst_map_pkg::*; #(
	parameter int FIELD_W = 1
) (
	input  wire logic               pclk_i,
	input  wire logic               arst_n_i,
	input  wire logic               sw_wr_i,
	input  wire logic [FIELD_W-1:0] sw_data_i,
	input  wire logic               hw_pulse_i,
	input  wire logic [FIELD_W-1:0] hw_next_i,
	output logic      [FIELD_W-1:0] value_o
);

	logic [FIELD_W-1:0] value_q;

	// Field storage
	// software write beats a hardware pulse in the same cycle
	always_ff @(posedge pclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			value_q <= {FIELD_W{RST_VAL}};
		end else if (sw_wr_i) begin
			value_q <= sw_data_i;
		end else if (hw_pulse_i) begin
			value_q <= hw_next_i;
		end
	end

	// Current value to hardware and read path
	assign value_o = value_q;

endmodule

`default_nettype wire

//--- hdl/regmst_map_pkg.sv
`default_nettype none

package regmst_map_pkg;

	import regmst_bus_pkg::*;

	// Word addresses of the internal registers
	localparam logic [ADDR_W-1:0] SNAP_LO_ADDR   = 64'h0;
	localparam logic [ADDR_W-1:0] SNAP_HI_ADDR   = 64'h4;
	localparam logic [ADDR_W-1:0] ERR_LOG_1_ADDR = 64'h8;

	// Error address register, split over two words
	localparam int ERR_ADDR_W = 64;

	// Single-bit fields at 0x8
	localparam int ERR_LOG_1_FIELDS = 2;

	// Bit positions inside the 0x8 word
	localparam int INTR_BIT       = 0;
	localparam int SOFT_RESET_BIT = 1;

	// Reset value, replicated to each field width
	localparam logic RST_VAL = 1'b0;

endpackage

`default_nettype wire

//--- hdl/regmst_bus_pkg.sv
`default_nettype none

package regmst_bus_pkg;

	// APB and request address width
	localparam int ADDR_W = 64;

	// Data word width
	localparam int DATA_W = 32;

	// Bridge states
	// IDLE waits for the access phase, REQ issues the request, WAIT_ACK holds the master
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		REQ      = 2'd1,
		WAIT_ACK = 2'd2
	} bridge_state_e;

	// Access opcode carried with each request
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_RD   = 2'd1,
		OP_WR   = 2'd2
	} access_op_e;

endpackage

`default_nettype wire
